// File: hw/coin_bank.sv
`timescale 1ns/1ps

module coin_bank import vend_pkg::*; (
    input  logic   clk,
    input  logic   rst,
    input  logic   coin_en,
    input  money_t coin_value,
    input  logic   deduct_en,
    input  money_t deduct_amount,
    input  logic   refund_start,
    output money_t balance,
    output logic   refund_busy,
    output logic   coin_out
);

    money_t                   coin_sum;
    logic                     coin_fits;
    logic [REFUND_TICK_W-1:0] tick_cnt;
    logic                     tick_wrap;

    // balance stays below 100 so the sum cannot wrap
    assign coin_sum  = balance + coin_value;
    assign coin_fits = (coin_sum < MONEY_LIMIT);

    assign tick_wrap = (tick_cnt == REFUND_TICK_W'(REFUND_TICK - 1));

    ////////////////////////////////////////////////////////////
    // balance and refund drain
    ////////////////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (!rst) begin
            balance     <= '0;
            refund_busy <= 1'b0;
            coin_out    <= 1'b0;
            tick_cnt    <= '0;
        end else begin
            coin_out <= 1'b0;
            if (refund_busy) begin
                // one unit leaves every REFUND_TICK cycles
                if (balance == '0) begin
                    refund_busy <= 1'b0;
                end else if (tick_wrap) begin
                    tick_cnt <= '0;
                    balance  <= balance - 1'b1;
                    coin_out <= 1'b1;
                    // last unit ends the refund on the same edge
                    if (balance == money_t'(1)) begin
                        refund_busy <= 1'b0;
                    end
                end else begin
                    tick_cnt <= tick_cnt + 1'b1;
                end
            end else begin
                if (refund_start) begin
                    refund_busy <= 1'b1;
                    tick_cnt    <= '0;
                end

                // coin that would reach the limit is dropped
                if (coin_en && coin_fits) begin
                    balance <= coin_sum;
                end else if (deduct_en) begin
                    balance <= balance - deduct_amount;
                end
            end
        end
    end

    a_money_limit: assert property (
        @(posedge clk) disable iff (!rst)
        balance < MONEY_LIMIT
    );

    // control side must hold money moves during a refund
    a_refund_quiet: assert property (
        @(posedge clk) disable iff (!rst)
        refund_busy |-> !coin_en && !deduct_en
    );

    a_deduct_covered: assert property (
        @(posedge clk) disable iff (!rst)
        deduct_en |-> deduct_amount <= balance
    );

endmodule

// File: hw/stock_store.sv
`timescale 1ns/1ps

module stock_store import vend_pkg::*; (
    input  logic       clk,
    input  logic       rst,
    input  logic       sell_en,
    input  prod_idx_t  sell_item,
    input  logic       restock_en,
    input  prod_idx_t  restock_item,
    output stock_arr_t stock
);

    logic restock_room;

    // full products ignore restock
    assign restock_room = (stock[restock_item] < STOCK_LIMIT);

    ////////////////////////////////////////////////////////////
    // stock counters
    ////////////////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (!rst) begin
            stock <= STOCK_INIT;
        end else begin
            if (sell_en) begin
                stock[sell_item] <= stock[sell_item] - 1'b1;
            end

            if (restock_en && restock_room) begin
                stock[restock_item] <= stock[restock_item] + 1'b1;
            end
        end
    end

    // per counter bound
    for (genvar i = 0; i < NUM_PROD; i++) begin : g_limit_chk
        a_stock_limit: assert property (
            @(posedge clk) disable iff (!rst)
            stock[i] <= STOCK_LIMIT
        );
    end

    // sold out check lives in the control block
    a_sell_nonempty: assert property (
        @(posedge clk) disable iff (!rst)
        sell_en |-> stock[sell_item] != '0
    );

    a_no_sell_restock: assert property (
        @(posedge clk) disable iff (!rst)
        !(sell_en && restock_en)
    );

endmodule

// File: hw/vend_ctrl.sv
`timescale 1ns/1ps

module vend_ctrl import vend_pkg::*; (
    input  logic         clk,
    input  logic         rst,
    input  logic         up,
    input  logic         down,
    input  logic         select,
    input  logic [2:0]   coin,
    input  logic         buy,
    input  logic         refund,
    input  logic         restock,
    input  logic         admin,
    input  logic         vend_ready,
    input  money_t       balance,
    input  logic         refund_busy,
    input  stock_arr_t   stock,
    output logic         vend_valid,
    output prod_idx_t    vend_item,
    output vend_status_t vend_status,
    output prod_idx_t    cursor,
    output logic         sel_valid,
    output prod_idx_t    sel_item,
    output logic         admin_mode,
    output stock_t       stock_current,
    output logic         coin_en,
    output money_t       coin_value,
    output logic         deduct_en,
    output money_t       deduct_amount,
    output logic         refund_start,
    output logic         sell_en,
    output prod_idx_t    sell_item,
    output logic         restock_en,
    output prod_idx_t    restock_item
);

    logic         act_move;
    logic         act_select;
    logic         act_coin;
    logic         act_buy;
    logic         act_refund;
    logic         act_restock;
    logic         act_admin;
    logic         buy_stall;
    logic         buy_go;
    logic         buy_ok;
    logic         sel_empty;
    logic         sel_short;
    money_t       sel_price;
    vend_status_t buy_status;

    ////////////////////////////////////////////////////////////
    // button priority
    ////////////////////////////////////////////////////////////

    // a held vend result blocks new buys
    assign buy_stall = vend_valid && !vend_ready;

    always_comb begin
        act_move    = 1'b0;
        act_select  = 1'b0;
        act_coin    = 1'b0;
        act_buy     = 1'b0;
        act_refund  = 1'b0;
        act_restock = 1'b0;
        act_admin   = 1'b0;
        if (up || down) begin
            act_move = 1'b1;
        end else if (select) begin
            act_select = 1'b1;
        end else if (coin != 3'b000) begin
            act_coin = 1'b1;
        end else if (buy) begin
            act_buy = !buy_stall;
        end else if (refund) begin
            act_refund = 1'b1;
        end else if (restock) begin
            act_restock = 1'b1;
        end else if (admin) begin
            act_admin = 1'b1;
        end
    end

    // coin bits are one-hot, msb is the smallest coin
    always_comb begin
        case (coin)
            3'b100:  coin_value = COIN_SMALL;
            3'b010:  coin_value = COIN_MID;
            3'b001:  coin_value = COIN_BIG;
            default: coin_value = '0;
        endcase
    end

    assign coin_en = act_coin && !refund_busy && (coin_value != '0);

    ////////////////////////////////////////////////////////////
    // buy decision
    ////////////////////////////////////////////////////////////

    assign sel_price = PRICE[sel_item];
    assign sel_empty = (stock[sel_item] == '0);
    // money being paid out cannot buy anything
    assign sel_short = (balance < sel_price) || refund_busy;
    assign buy_go    = act_buy && sel_valid;
    assign buy_ok    = buy_go && !sel_empty && !sel_short;

    always_comb begin
        if (sel_empty) begin
            buy_status = ST_SOLD_OUT;
        end else if (sel_short) begin
            buy_status = ST_NO_MONEY;
        end else begin
            buy_status = ST_OK;
        end
    end

    assign sell_en       = buy_ok;
    assign sell_item     = sel_item;
    assign deduct_en     = buy_ok;
    assign deduct_amount = sel_price;

    assign refund_start = act_refund;

    // restock only from admin mode
    assign restock_en   = act_restock && admin_mode;
    assign restock_item = cursor;

    assign stock_current = stock[cursor];

    ////////////////////////////////////////////////////////////
    // cursor, selection, admin, vend channel
    ////////////////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (!rst) begin
            cursor     <= '0;
            sel_valid  <= 1'b0;
            sel_item   <= '0;
            admin_mode <= 1'b0;
            vend_valid <= 1'b0;
        end else begin
            // up moves toward product 0
            if (act_move) begin
                if (up) begin
                    if (cursor != '0) begin
                        cursor <= cursor - 1'b1;
                    end
                end else if (cursor != prod_idx_t'(NUM_PROD - 1)) begin
                    cursor <= cursor + 1'b1;
                end
            end

            // second select on the same product deselects it
            if (act_select) begin
                if (sel_valid && (sel_item == cursor)) begin
                    sel_valid <= 1'b0;
                end else if (stock[cursor] != '0) begin
                    sel_valid <= 1'b1;
                    sel_item  <= cursor;
                end
            end

            if (buy_go) begin
                sel_valid <= 1'b0;
            end

            if (act_admin) begin
                admin_mode <= !admin_mode;
            end

            if (buy_go) begin
                vend_valid <= 1'b1;
            end else if (vend_ready) begin
                vend_valid <= 1'b0;
            end
        end
    end

    // result payload
    always_ff @(posedge clk) begin
        if (buy_go) begin
            vend_item   <= sel_item;
            vend_status <= buy_status;
        end
    end

    a_vend_hold: assert property (
        @(posedge clk) disable iff (!rst)
        vend_valid && !vend_ready |=>
            vend_valid && $stable(vend_item) && $stable(vend_status)
    );

endmodule

// File: hw/vend_pkg.sv
package vend_pkg;

    ////////////////////////////////////////////////////////////
    // widths and types
    ////////////////////////////////////////////////////////////

    localparam int NUM_PROD = 4;

    // product index, matches the cursor range
    typedef logic [1:0] prod_idx_t;

    // items held for one product
    typedef logic [3:0] stock_t;

    // counts of every product, index 0 is the first product
    typedef stock_t [NUM_PROD-1:0] stock_arr_t;

    // balance in 100 won units
    typedef logic [7:0] money_t;

    ////////////////////////////////////////////////////////////
    // product table
    ////////////////////////////////////////////////////////////

    // prices of products 0..3 are 10, 12, 15 and 18
    localparam money_t [NUM_PROD-1:0] PRICE = {8'd18, 8'd15, 8'd12, 8'd10};

    // counts after reset, product 2 starts sold out
    localparam stock_arr_t STOCK_INIT = {4'd4, 4'd0, 4'd1, 4'd9};

    // one digit per product on the front panel
    localparam stock_t STOCK_LIMIT = 4'd9;

    ////////////////////////////////////////////////////////////
    // money
    ////////////////////////////////////////////////////////////

    // balance must stay strictly below this
    localparam money_t MONEY_LIMIT = 8'd100;

    // 100, 500 and 1000 won coins
    localparam money_t COIN_SMALL = 8'd1;
    localparam money_t COIN_MID   = 8'd5;
    localparam money_t COIN_BIG   = 8'd10;

    // cycles per refunded unit, roughly 1000000 on the board
    localparam int REFUND_TICK   = 4;
    localparam int REFUND_TICK_W = $clog2(REFUND_TICK);

    ////////////////////////////////////////////////////////////
    // vend result status
    ////////////////////////////////////////////////////////////

    typedef enum logic [1:0] {
        ST_OK       = 2'd0,
        ST_NO_MONEY = 2'd1,
        ST_SOLD_OUT = 2'd2
    } vend_status_t;

endpackage

// File: hw/vending_top.sv
`timescale 1ns/1ps

module vending_top import vend_pkg::*; (
    input  logic         clk,
    input  logic         rst,
    input  logic         up,
    input  logic         down,
    input  logic         select,
    input  logic [2:0]   coin,
    input  logic         buy,
    input  logic         refund,
    input  logic         restock,
    input  logic         admin,
    input  logic         vend_ready,
    output logic         vend_valid,
    output prod_idx_t    vend_item,
    output vend_status_t vend_status,
    output money_t       balance,
    output logic         coin_out,
    output logic         refund_busy,
    output prod_idx_t    cursor,
    output logic         sel_valid,
    output prod_idx_t    sel_item,
    output logic         admin_mode,
    output stock_t       stock_current
);

    logic       coin_en;
    money_t     coin_value;
    logic       deduct_en;
    money_t     deduct_amount;
    logic       refund_start;
    logic       sell_en;
    prod_idx_t  sell_item;
    logic       restock_en;
    prod_idx_t  restock_item;
    stock_arr_t stock;

    vend_ctrl u_ctrl (
        .clk           (clk),
        .rst           (rst),
        .up            (up),
        .down          (down),
        .select        (select),
        .coin          (coin),
        .buy           (buy),
        .refund        (refund),
        .restock       (restock),
        .admin         (admin),
        .vend_ready    (vend_ready),
        .balance       (balance),
        .refund_busy   (refund_busy),
        .stock         (stock),
        .vend_valid    (vend_valid),
        .vend_item     (vend_item),
        .vend_status   (vend_status),
        .cursor        (cursor),
        .sel_valid     (sel_valid),
        .sel_item      (sel_item),
        .admin_mode    (admin_mode),
        .stock_current (stock_current),
        .coin_en       (coin_en),
        .coin_value    (coin_value),
        .deduct_en     (deduct_en),
        .deduct_amount (deduct_amount),
        .refund_start  (refund_start),
        .sell_en       (sell_en),
        .sell_item     (sell_item),
        .restock_en    (restock_en),
        .restock_item  (restock_item)
    );

    // money datapath
    coin_bank u_bank (
        .clk           (clk),
        .rst           (rst),
        .coin_en       (coin_en),
        .coin_value    (coin_value),
        .deduct_en     (deduct_en),
        .deduct_amount (deduct_amount),
        .refund_start  (refund_start),
        .balance       (balance),
        .refund_busy   (refund_busy),
        .coin_out      (coin_out)
    );

    // product counts
    stock_store u_stock (
        .clk          (clk),
        .rst          (rst),
        .sell_en      (sell_en),
        .sell_item    (sell_item),
        .restock_en   (restock_en),
        .restock_item (restock_item),
        .stock        (stock)
    );

endmodule

// File: run_sim.sh
#!/bin/bash
# build the testbench with Verilator, run it and judge the log
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log

verilator --binary --timing --assert -Wno-fatal -f src.f --top-module vend_tb -o vend_sim \
    && ./obj_dir/vend_sim > sim.log 2>&1 \
    || echo "build or simulation run returned an error"

cat sim.log 2>/dev/null
grep -qx "STATUS: PASS" sim.log 2>/dev/null && echo "simulation passed" && exit 0 \
    || { echo "simulation failed"; exit 1; }

// File: sim/vend_tb_table.svh
// columns: button, vend_ready, wait, balance, stock_current, cursor,
// sel_valid, vend_valid, vend_item, vend_status

localparam int BAL_A   = COIN_SMALL + COIN_MID + COIN_BIG;
localparam int BAL_B   = BAL_A - PRICE[0];
localparam int BAL_C   = BAL_B + COIN_BIG;
localparam int BAL_D   = BAL_C - PRICE[1];
localparam int S0      = STOCK_INIT[0];
localparam int S0_SOLD = STOCK_INIT[0] - 1;
localparam int S1_SOLD = STOCK_INIT[1] - 1;

task automatic load_steps();
    // coins
    row(B_COIN1,   1, 0, COIN_SMALL,            S0,            0, 0, 0, 0, ST_OK);
    row(B_COIN5,   1, 0, COIN_SMALL + COIN_MID, S0,            0, 0, 0, 0, ST_OK);
    row(B_COIN10,  1, 0, BAL_A, S0,                            0, 0, 0, 0, ST_OK);
    // cursor walk, product 2 is sold out
    row(B_DOWN,    1, 0, BAL_A, STOCK_INIT[1],                 1, 0, 0, 0, ST_OK);
    row(B_DOWN,    1, 0, BAL_A, STOCK_INIT[2],                 2, 0, 0, 0, ST_OK);
    row(B_SELECT,  1, 0, BAL_A, STOCK_INIT[2],                 2, 0, 0, 0, ST_OK);
    row(B_DOWN,    1, 0, BAL_A, STOCK_INIT[3],                 3, 0, 0, 0, ST_OK);
    row(B_DOWN,    1, 0, BAL_A, STOCK_INIT[3],                 3, 0, 0, 0, ST_OK);
    row(B_UP,      1, 0, BAL_A, STOCK_INIT[2],                 2, 0, 0, 0, ST_OK);
    row(B_UP,      1, 0, BAL_A, STOCK_INIT[1],                 1, 0, 0, 0, ST_OK);
    row(B_UP,      1, 0, BAL_A, S0,                            0, 0, 0, 0, ST_OK);
    row(B_UP,      1, 0, BAL_A, S0,                            0, 0, 0, 0, ST_OK);
    row(B_SELECT,  1, 0, BAL_A, S0,                            0, 1, 0, 0, ST_OK);
    row(B_SELECT,  1, 0, BAL_A, S0,                            0, 0, 0, 0, ST_OK);
    row(B_SELECT,  1, 0, BAL_A, S0,                            0, 1, 0, 0, ST_OK);
    // buy with enough money, then one short
    row(B_BUY,     1, 0, BAL_B, S0_SOLD,                       0, 0, 1, 0, ST_OK);
    row(B_NONE,    1, 0, BAL_B, S0_SOLD,                       0, 0, 0, 0, ST_OK);
    row(B_SELECT,  1, 0, BAL_B, S0_SOLD,                       0, 1, 0, 0, ST_OK);
    row(B_BUY,     1, 0, BAL_B, S0_SOLD,                       0, 0, 1, 0, ST_NO_MONEY);
    row(B_NONE,    1, 0, BAL_B, S0_SOLD,                       0, 0, 0, 0, ST_OK);
    // back-pressure on the vend result
    row(B_COIN10,  1, 0, BAL_C, S0_SOLD,                       0, 0, 0, 0, ST_OK);
    row(B_DOWN,    1, 0, BAL_C, STOCK_INIT[1],                 1, 0, 0, 0, ST_OK);
    row(B_SELECT,  1, 0, BAL_C, STOCK_INIT[1],                 1, 1, 0, 0, ST_OK);
    row(B_BUY,     0, 0, BAL_D, S1_SOLD,                       1, 0, 1, 1, ST_OK);
    row(B_NONE,    0, 3, BAL_D, S1_SOLD,                       1, 0, 1, 1, ST_OK);
    row(B_UP,      0, 0, BAL_D, S0_SOLD,                       0, 0, 1, 1, ST_OK);
    row(B_SELECT,  0, 0, BAL_D, S0_SOLD,                       0, 1, 1, 1, ST_OK);
    row(B_BUY,     0, 0, BAL_D, S0_SOLD,                       0, 1, 1, 1, ST_OK);
    row(B_NONE,    1, 0, BAL_D, S0_SOLD,                       0, 1, 0, 0, ST_OK);
    row(B_SELECT,  1, 0, BAL_D, S0_SOLD,                       0, 0, 0, 0, ST_OK);
    // restock, first press outside admin mode
    row(B_RESTOCK, 1, 0, BAL_D, S0_SOLD,                       0, 0, 0, 0, ST_OK);
    row(B_ADMIN,   1, 0, BAL_D, S0_SOLD,                       0, 0, 0, 0, ST_OK);
    row(B_RESTOCK, 1, 0, BAL_D, restocked(S0_SOLD),            0, 0, 0, 0, ST_OK);
    row(B_RESTOCK, 1, 0, BAL_D, restocked(restocked(S0_SOLD)), 0, 0, 0, 0, ST_OK);
    row(B_DOWN,    1, 0, BAL_D, S1_SOLD,                       1, 0, 0, 0, ST_OK);
    row(B_RESTOCK, 1, 0, BAL_D, restocked(S1_SOLD),            1, 0, 0, 0, ST_OK);
    row(B_ADMIN,   1, 0, BAL_D, restocked(S1_SOLD),            1, 0, 0, 0, ST_OK);
    row(B_RESTOCK, 1, 0, BAL_D, restocked(S1_SOLD),            1, 0, 0, 0, ST_OK);
endtask

// File: sim/vend_tb.sv
`timescale 1ns/1ps

module vend_tb import vend_pkg::*; ();

    localparam int CLK_PERIOD   = 8;
    localparam int RESET_CYCLES = 10;
    localparam int RAND_SEED    = 97;
    localparam int RAND_COINS   = 40;
    localparam int FILL_MAX     = MONEY_LIMIT / COIN_BIG + 1;
    localparam int MARGIN       = 200;

    // button codes used by the table
    localparam int B_NONE    = 0;
    localparam int B_UP      = 1;
    localparam int B_DOWN    = 2;
    localparam int B_SELECT  = 3;
    localparam int B_COIN1   = 4;
    localparam int B_COIN5   = 5;
    localparam int B_COIN10  = 6;
    localparam int B_BUY     = 7;
    localparam int B_REFUND  = 8;
    localparam int B_RESTOCK = 9;
    localparam int B_ADMIN   = 10;

    typedef struct packed {
        logic [3:0] btn;
        logic       ready;
        logic [7:0] wait_cyc;
        logic [7:0] exp_balance;
        logic [3:0] exp_stock;
        logic [1:0] exp_cursor;
        logic       exp_sel;
        logic       exp_vvalid;
        logic [1:0] exp_vitem;
        logic [1:0] exp_vstatus;
    } step_t;

    logic         clk;
    logic         rst;
    logic         up;
    logic         down;
    logic         select;
    logic [2:0]   coin;
    logic         buy;
    logic         refund;
    logic         restock;
    logic         admin;
    logic         vend_ready;
    logic         vend_valid;
    prod_idx_t    vend_item;
    vend_status_t vend_status;
    money_t       balance;
    logic         coin_out;
    logic         refund_busy;
    prod_idx_t    cursor;
    logic         sel_valid;
    prod_idx_t    sel_item;
    logic         admin_mode;
    stock_t       stock_current;

    step_t steps[$];
    bit    table_loaded = 1'b0;
    int    errors       = 0;
    int    checks       = 0;
    int    cur_step     = -1;
    int    model_bal    = 0;
    int    sel_pick     = 0;

    vending_top dut0 (
        .clk           (clk),
        .rst           (rst),
        .up            (up),
        .down          (down),
        .select        (select),
        .coin          (coin),
        .buy           (buy),
        .refund        (refund),
        .restock       (restock),
        .admin         (admin),
        .vend_ready    (vend_ready),
        .vend_valid    (vend_valid),
        .vend_item     (vend_item),
        .vend_status   (vend_status),
        .balance       (balance),
        .coin_out      (coin_out),
        .refund_busy   (refund_busy),
        .cursor        (cursor),
        .sel_valid     (sel_valid),
        .sel_item      (sel_item),
        .admin_mode    (admin_mode),
        .stock_current (stock_current)
    );

    ////////////////////////////////////////////////////////////
    // reference rules
    ////////////////////////////////////////////////////////////

    function automatic int coin_value_of(int btn);
        case (btn)
            B_COIN1:  return COIN_SMALL;
            B_COIN5:  return COIN_MID;
            B_COIN10: return COIN_BIG;
            default:  return 0;
        endcase
    endfunction

    // one restock press, capped at the product limit
    function automatic int restocked(int n);
        return (n < STOCK_LIMIT) ? n + 1 : n;
    endfunction

    function automatic void row(int btn, int rdy, int wt, int bal, int stk, int cur,
                                int sel, int vv, int item, int st);
        step_t s;
        s.btn         = 4'(btn);
        s.ready       = rdy[0];
        s.wait_cyc    = 8'(wt);
        s.exp_balance = 8'(bal);
        s.exp_stock   = 4'(stk);
        s.exp_cursor  = 2'(cur);
        s.exp_sel     = sel[0];
        s.exp_vvalid  = vv[0];
        s.exp_vitem   = 2'(item);
        s.exp_vstatus = 2'(st);
        steps.push_back(s);
    endfunction

    `include "vend_tb_table.svh"

    ////////////////////////////////////////////////////////////
    // drive and check helpers
    ////////////////////////////////////////////////////////////

    task automatic check_val(string name, int got, int exp);
        checks++;
        assert (got == exp) else begin
            errors++;
            $display("[ERROR] t=%0t step %0d %s: got %0d expected %0d",
                     $time, cur_step, name, got, exp);
        end
    endtask

    task automatic press(int btn);
        case (btn)
            B_UP:      up      = 1'b1;
            B_DOWN:    down    = 1'b1;
            B_SELECT:  select  = 1'b1;
            B_COIN1:   coin    = 3'b100;
            B_COIN5:   coin    = 3'b010;
            B_COIN10:  coin    = 3'b001;
            B_BUY:     buy     = 1'b1;
            B_REFUND:  refund  = 1'b1;
            B_RESTOCK: restock = 1'b1;
            B_ADMIN:   admin   = 1'b1;
            default:   ;
        endcase
    endtask

    task automatic release_buttons();
        up      = 1'b0;
        down    = 1'b0;
        select  = 1'b0;
        coin    = 3'b000;
        buy     = 1'b0;
        refund  = 1'b0;
        restock = 1'b0;
        admin   = 1'b0;
    endtask

    // entered right after a falling edge
    task automatic apply_step(step_t s);
        vend_ready = s.ready;
        press(int'(s.btn));
        @(negedge clk);
        release_buttons();
        repeat (int'(s.wait_cyc)) @(negedge clk);
        // a select that takes picks the product under the cursor
        if ((int'(s.btn) == B_SELECT) && s.exp_sel) begin
            sel_pick = int'(s.exp_cursor);
        end
        check_val("balance", int'(balance), int'(s.exp_balance));
        check_val("stock_current", int'(stock_current), int'(s.exp_stock));
        check_val("cursor", int'(cursor), int'(s.exp_cursor));
        check_val("sel_valid", int'(sel_valid), int'(s.exp_sel));
        if (s.exp_sel) begin
            check_val("sel_item", int'(sel_item), sel_pick);
        end
        check_val("vend_valid", int'(vend_valid), int'(s.exp_vvalid));
        if (s.exp_vvalid) begin
            check_val("vend_item", int'(vend_item), int'(s.exp_vitem));
            check_val("vend_status", int'(vend_status), int'(s.exp_vstatus));
        end
    endtask

    // other outputs keep the state of the last table row
    task automatic coin_step(int btn);
        step_t s;
        int    value;
        s     = steps[steps.size() - 1];
        value = coin_value_of(btn);
        if (model_bal + value < MONEY_LIMIT) begin
            model_bal = model_bal + value;
        end
        s.btn         = 4'(btn);
        s.ready       = 1'b1;
        s.wait_cyc    = 8'd0;
        s.exp_balance = 8'(model_bal);
        s.exp_vvalid  = 1'b0;
        apply_step(s);
    endtask

    task automatic run_refund();
        int bal0;
        int limit;
        int n;
        int pulses;
        bal0   = model_bal;
        limit  = bal0 * REFUND_TICK;
        n      = 0;
        pulses = 0;
        refund = 1'b1;
        @(negedge clk);
        refund = 1'b0;
        check_val("refund_busy", int'(refund_busy), 1);
        check_val("balance", int'(balance), bal0);
        // one unit and one coin_out pulse per tick period
        while (refund_busy && (n <= limit)) begin
            @(negedge clk);
            n++;
            if (coin_out) begin
                pulses++;
            end
            check_val("balance", int'(balance), bal0 - n / REFUND_TICK);
            check_val("coin_out", int'(coin_out), int'(n % REFUND_TICK == 0));
        end
        checks++;
        assert (!refund_busy) else begin
            errors++;
            $display("refund still busy after %0d cycles, drain never finished", n);
        end
        check_val("refund_cycles", n, limit);
        check_val("coin_out_pulses", pulses, bal0);
        check_val("balance", int'(balance), 0);
        model_bal = 0;
    endtask

    ////////////////////////////////////////////////////////////
    // clock, watchdog, main sequence
    ////////////////////////////////////////////////////////////

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    initial begin : watchdog
        int     max_wait;
        longint limit_cycles;
        max_wait = 0;
        wait (table_loaded);
        foreach (steps[i]) begin
            if (int'(steps[i].wait_cyc) > max_wait) begin
                max_wait = int'(steps[i].wait_cyc);
            end
        end
        limit_cycles = RESET_CYCLES + steps.size() * (max_wait + 2)
                     + (RAND_COINS + FILL_MAX + 1) * 2
                     + (MONEY_LIMIT + 2) * REFUND_TICK + MARGIN;
        #(limit_cycles * CLK_PERIOD);
        $display("watchdog expired after %0d cycles, run stopped", limit_cycles);
        $display("STATUS: FAIL");
        $finish;
    end

    initial begin
        int btn;
        void'($urandom(RAND_SEED));
        rst        = 1'b0;
        vend_ready = 1'b1;
        release_buttons();
        load_steps();
        table_loaded = 1'b1;

        repeat (RESET_CYCLES) @(posedge clk);
        @(negedge clk);
        rst = 1'b1;
        check_val("vend_valid", int'(vend_valid), 0);
        check_val("coin_out", int'(coin_out), 0);
        check_val("refund_busy", int'(refund_busy), 0);
        check_val("admin_mode", int'(admin_mode), 0);

        for (int i = 0; i < steps.size(); i++) begin
            cur_step = i;
            apply_step(steps[i]);
        end

        // random coin order, then top up until a big coin must bounce
        cur_step  = -1;
        model_bal = int'(steps[steps.size() - 1].exp_balance);
        for (int i = 0; i < RAND_COINS; i++) begin
            btn = B_COIN1 + int'($urandom % 3);
            coin_step(btn);
        end
        while (model_bal + COIN_BIG < MONEY_LIMIT) begin
            coin_step(B_COIN10);
        end
        // this one would reach the limit, balance must not move
        coin_step(B_COIN10);

        run_refund();

        $display("checks run: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("STATUS: PASS");
        end else begin
            $display("STATUS: FAIL");
        end
        $finish;
    end

endmodule

// File: src.f
+incdir+sim
hw/vend_pkg.sv
hw/coin_bank.sv
hw/stock_store.sv
hw/vend_ctrl.sv
hw/vending_top.sv
sim/vend_tb.sv
